// ==== verilog/id_pkg.sv ====
`default_nettype none

package id_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	typedef logic [XLEN-1:0]       word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// RV32I major opcodes
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

	localparam word_t LINK_OFFSET = 32'd4; // Return address is the next word

	typedef enum logic [7:0] {
		ALU_NOP,
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_AUIPC,
		ALU_LB,
		ALU_LH,
		ALU_LW,
		ALU_LBU,
		ALU_LHU,
		ALU_SB,
		ALU_SH,
		ALU_SW
	} alu_op_e;

	typedef enum logic [2:0] {
		RES_NOP,
		RES_LOGIC,
		RES_SHIFT,
		RES_ARITH,
		RES_JUMP_BRANCH,
		RES_LOAD_STORE
	} alu_sel_e;

	// Same code as funct3 of the branch group
	typedef enum logic [2:0] {
		BR_EQ  = 3'b000,
		BR_NE  = 3'b001,
		BR_LT  = 3'b100,
		BR_GE  = 3'b101,
		BR_LTU = 3'b110,
		BR_GEU = 3'b111
	} br_cond_e;

	function automatic logic is_load(alu_op_e op);
		return op inside {ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU};
	endfunction

endpackage

`default_nettype wire

// ==== verilog/inst_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_decoder (
	input  logic              inst_valid_i,
	input  id_pkg::word_t     pc_i,
	input  id_pkg::word_t     inst_i,
	output id_pkg::alu_op_e   aluop_o,
	output id_pkg::alu_sel_e  alusel_o,
	output id_pkg::reg_addr_t wd_o,
	output logic              wreg_o,
	output id_pkg::reg_addr_t rs1_addr_o,
	output id_pkg::reg_addr_t rs2_addr_o,
	output logic              use_rs1_o,
	output logic              use_rs2_o,
	output id_pkg::word_t     imm_o,
	output id_pkg::word_t     alt1_o,
	output logic              is_branch_o,
	output logic              is_jal_o,
	output id_pkg::br_cond_e  br_cond_o,
	output logic              legal_o
);
	import id_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_j;
	word_t      imm_u;
	word_t      imm_sh;
	alu_op_e    f3_op;
	alu_sel_e   f3_sel;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];

	assign imm_i  = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_s  = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b  = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_j  = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
	assign imm_u  = {inst_i[31:12], 12'b0};
	assign imm_sh = {{(XLEN-REG_ADDR_W){1'b0}}, inst_i[24:20]};

	assign wd_o       = inst_i[11:7];
	assign rs1_addr_o = inst_i[19:15];
	assign rs2_addr_o = inst_i[24:20];
	assign br_cond_o  = br_cond_e'(funct3);

	// ALU operation shared by OP and OP-IMM
	always_comb begin
		case (funct3)
			3'b000: f3_op = (opcode == OPC_OP && inst_i[30]) ? ALU_SUB : ALU_ADD;
			3'b001: f3_op = ALU_SLL;
			3'b010: f3_op = ALU_SLT;
			3'b011: f3_op = ALU_SLTU;
			3'b100: f3_op = ALU_XOR;
			3'b101: f3_op = inst_i[30] ? ALU_SRA : ALU_SRL;
			3'b110: f3_op = ALU_OR;
			default: f3_op = ALU_AND;
		endcase
		case (f3_op)
			ALU_SLL, ALU_SRL, ALU_SRA: f3_sel = RES_SHIFT;
			ALU_XOR, ALU_OR, ALU_AND:  f3_sel = RES_LOGIC;
			default:                   f3_sel = RES_ARITH;
		endcase
	end

	always_comb begin
		aluop_o     = ALU_NOP;
		alusel_o    = RES_NOP;
		wreg_o      = 1'b0;
		use_rs1_o   = 1'b0;
		use_rs2_o   = 1'b0;
		imm_o       = '0;
		is_branch_o = 1'b0;
		is_jal_o    = 1'b0;
		legal_o     = 1'b1;
		case (opcode)
			OPC_LOAD: begin
				alusel_o  = RES_LOAD_STORE;
				wreg_o    = 1'b1;
				use_rs1_o = 1'b1;
				imm_o     = imm_i;
				case (funct3)
					3'b000: aluop_o = ALU_LB;
					3'b001: aluop_o = ALU_LH;
					3'b010: aluop_o = ALU_LW;
					3'b100: aluop_o = ALU_LBU;
					3'b101: aluop_o = ALU_LHU;
					default: legal_o = 1'b0;
				endcase
			end
			OPC_STORE: begin
				alusel_o  = RES_LOAD_STORE;
				use_rs1_o = 1'b1;
				use_rs2_o = 1'b1;
				imm_o     = imm_s;
				case (funct3)
					3'b000: aluop_o = ALU_SB;
					3'b001: aluop_o = ALU_SH;
					3'b010: aluop_o = ALU_SW;
					default: legal_o = 1'b0;
				endcase
			end
			OPC_BRANCH: begin
				alusel_o    = RES_JUMP_BRANCH;
				use_rs1_o   = 1'b1;
				use_rs2_o   = 1'b1;
				is_branch_o = 1'b1;
				imm_o       = imm_b;
				legal_o     = (funct3[2:1] != 2'b01); // 010 and 011 are unused
			end
			OPC_JAL: begin
				alusel_o = RES_JUMP_BRANCH;
				wreg_o   = 1'b1;
				is_jal_o = 1'b1;
				imm_o    = imm_j;
			end
			OPC_OP_IMM: begin
				aluop_o   = f3_op;
				alusel_o  = f3_sel;
				wreg_o    = 1'b1;
				use_rs1_o = 1'b1;
				imm_o     = (f3_sel == RES_SHIFT) ? imm_sh : imm_i;
			end
			OPC_OP: begin
				aluop_o   = f3_op;
				alusel_o  = f3_sel;
				wreg_o    = 1'b1;
				use_rs1_o = 1'b1;
				use_rs2_o = 1'b1;
			end
			OPC_LUI: begin
				aluop_o  = ALU_OR; // imm | imm gives the upper immediate
				alusel_o = RES_LOGIC;
				wreg_o   = 1'b1;
				imm_o    = imm_u;
			end
			OPC_AUIPC: begin
				aluop_o  = ALU_AUIPC;
				alusel_o = RES_ARITH;
				wreg_o   = 1'b1;
				imm_o    = imm_u;
			end
			default: legal_o = 1'b0;
		endcase

		// Nothing reads or writes for an empty or undecoded slot
		if (!inst_valid_i || !legal_o) begin
			aluop_o     = ALU_NOP;
			alusel_o    = RES_NOP;
			wreg_o      = 1'b0;
			use_rs1_o   = 1'b0;
			use_rs2_o   = 1'b0;
			is_branch_o = 1'b0;
			is_jal_o    = 1'b0;
		end
	end

	assign alt1_o = (aluop_o == ALU_AUIPC) ? pc_i : imm_o;

endmodule

`default_nettype wire

// ==== verilog/operand_bypass.sv ====
`timescale 1ns/100ps
`default_nettype none

module operand_bypass (
	input  logic              use_i,
	input  id_pkg::reg_addr_t addr_i,
	input  id_pkg::word_t     rf_data_i,
	input  id_pkg::word_t     alt_i,
	input  logic              ex_wreg_i,
	input  id_pkg::reg_addr_t ex_wd_i,
	input  id_pkg::word_t     ex_wdata_i,
	input  id_pkg::alu_op_e   ex_aluop_i,
	input  logic              mem_wreg_i,
	input  id_pkg::reg_addr_t mem_wd_i,
	input  id_pkg::word_t     mem_wdata_i,
	input  id_pkg::alu_op_e   mem_aluop_i,
	output id_pkg::word_t     operand_o,
	output logic              load_hazard_o
);
	import id_pkg::*;

	logic src_live;
	logic ex_match;
	logic mem_match;

	assign src_live  = use_i && (addr_i != reg_addr_t'(0)); // x0 reads as zero
	assign ex_match  = src_live && (ex_wd_i == addr_i);
	assign mem_match = src_live && (mem_wd_i == addr_i);

	always_comb begin
		if (!use_i) begin
			operand_o = alt_i;
		end else if (ex_match && ex_wreg_i) begin
			operand_o = ex_wdata_i; // Youngest result wins
		end else if (mem_match && mem_wreg_i) begin
			operand_o = mem_wdata_i;
		end else begin
			operand_o = rf_data_i;
		end
	end

	// Load data is not ready yet in either stage
	assign load_hazard_o = (ex_match && is_load(ex_aluop_i)) ||
	                       (mem_match && is_load(mem_aluop_i));

endmodule

`default_nettype wire

// ==== verilog/branch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_unit (
	input  id_pkg::word_t    pc_i,
	input  id_pkg::word_t    imm_i,
	input  id_pkg::word_t    op_a_i,
	input  id_pkg::word_t    op_b_i,
	input  logic             is_branch_i,
	input  logic             is_jal_i,
	input  id_pkg::br_cond_e br_cond_i,
	output logic             taken_o,
	output id_pkg::word_t    target_o,
	output id_pkg::word_t    link_o
);
	import id_pkg::*;

	logic cond_met;

	always_comb begin
		case (br_cond_i)
			BR_EQ:   cond_met = (op_a_i == op_b_i);
			BR_NE:   cond_met = (op_a_i != op_b_i);
			BR_LT:   cond_met = ($signed(op_a_i) < $signed(op_b_i));
			BR_GE:   cond_met = ($signed(op_a_i) >= $signed(op_b_i));
			BR_LTU:  cond_met = (op_a_i < op_b_i);
			BR_GEU:  cond_met = (op_a_i >= op_b_i);
			default: cond_met = 1'b0;
		endcase
	end

	assign taken_o = is_jal_i || (is_branch_i && cond_met); // JAL always redirects

	// Both B and J offsets are relative to this pc
	assign target_o = pc_i + imm_i;

	assign link_o = is_jal_i ? (pc_i + LINK_OFFSET) : '0;

endmodule

`default_nettype wire

// ==== verilog/idex_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module idex_reg (
	input  logic              clk_i,
	input  logic              arst_n_i,
	input  logic              stall_i,
	input  logic              legal_i,
	input  logic              inst_valid_i,
	input  id_pkg::alu_op_e   aluop_i,
	input  id_pkg::alu_sel_e  alusel_i,
	input  id_pkg::reg_addr_t wd_i,
	input  logic              wreg_i,
	input  id_pkg::word_t     reg1_i,
	input  id_pkg::word_t     reg2_i,
	input  id_pkg::word_t     imm_i,
	input  logic              taken_i,
	input  id_pkg::word_t     target_i,
	input  id_pkg::word_t     link_i,
	output logic              valid_o,
	output logic              illegal_o,
	output id_pkg::alu_op_e   aluop_o,
	output id_pkg::alu_sel_e  alusel_o,
	output id_pkg::reg_addr_t wd_o,
	output logic              wreg_o,
	output id_pkg::word_t     reg1_o,
	output id_pkg::word_t     reg2_o,
	output id_pkg::word_t     imm_o,
	output logic              branch_flag_o,
	output id_pkg::word_t     branch_target_o,
	output id_pkg::word_t     link_addr_o
);
	import id_pkg::*;

	logic issue;

	assign issue = inst_valid_i && legal_i && !stall_i;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_o       <= 1'b0;
			illegal_o     <= 1'b0;
			aluop_o       <= ALU_NOP;
			alusel_o      <= RES_NOP;
			wreg_o        <= 1'b0;
			branch_flag_o <= 1'b0;
		end else begin
			valid_o       <= issue;
			illegal_o     <= inst_valid_i && !legal_i && !stall_i;
			aluop_o       <= issue ? aluop_i : ALU_NOP; // Bubble otherwise
			alusel_o      <= issue ? alusel_i : RES_NOP;
			wreg_o        <= issue && wreg_i;
			branch_flag_o <= issue && taken_i;
		end
	end

	always_ff @(posedge clk_i) begin
		wd_o            <= wd_i;
		reg1_o          <= reg1_i;
		reg2_o          <= reg2_i;
		imm_o           <= imm_i;
		branch_target_o <= target_i;
		link_addr_o     <= link_i;
	end

endmodule

`default_nettype wire

// ==== verilog/id_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module id_stage (
	input  logic              clk_i,
	input  logic              arst_n_i,
	input  logic              inst_valid_i,
	input  id_pkg::word_t     pc_i,
	input  id_pkg::word_t     inst_i,
	input  id_pkg::word_t     reg1_data_i,
	input  id_pkg::word_t     reg2_data_i,
	input  logic              ex_wreg_i,
	input  id_pkg::reg_addr_t ex_wd_i,
	input  id_pkg::word_t     ex_wdata_i,
	input  id_pkg::alu_op_e   ex_aluop_i,
	input  logic              mem_wreg_i,
	input  id_pkg::reg_addr_t mem_wd_i,
	input  id_pkg::word_t     mem_wdata_i,
	input  id_pkg::alu_op_e   mem_aluop_i,
	output id_pkg::reg_addr_t reg1_addr_o,
	output id_pkg::reg_addr_t reg2_addr_o,
	output logic              stall_o,
	output logic              valid_o,
	output logic              illegal_o,
	output id_pkg::alu_op_e   aluop_o,
	output id_pkg::alu_sel_e  alusel_o,
	output id_pkg::reg_addr_t wd_o,
	output logic              wreg_o,
	output id_pkg::word_t     reg1_o,
	output id_pkg::word_t     reg2_o,
	output id_pkg::word_t     imm_o,
	output logic              branch_flag_o,
	output id_pkg::word_t     branch_target_o,
	output id_pkg::word_t     link_addr_o
);
	import id_pkg::*;

	alu_op_e   dec_aluop;
	alu_sel_e  dec_alusel;
	reg_addr_t dec_wd;
	logic      dec_wreg;
	logic      use_rs1;
	logic      use_rs2;
	word_t     dec_imm;
	word_t     alt1;
	logic      is_branch;
	logic      is_jal;
	br_cond_e  br_cond;
	logic      legal;
	word_t     op1;
	word_t     op2;
	logic      hazard1;
	logic      hazard2;
	logic      taken;
	word_t     target;
	word_t     link;

	inst_decoder u_decoder (
		.inst_valid_i (inst_valid_i),
		.pc_i         (pc_i),
		.inst_i       (inst_i),
		.aluop_o      (dec_aluop),
		.alusel_o     (dec_alusel),
		.wd_o         (dec_wd),
		.wreg_o       (dec_wreg),
		.rs1_addr_o   (reg1_addr_o),
		.rs2_addr_o   (reg2_addr_o),
		.use_rs1_o    (use_rs1),
		.use_rs2_o    (use_rs2),
		.imm_o        (dec_imm),
		.alt1_o       (alt1),
		.is_branch_o  (is_branch),
		.is_jal_o     (is_jal),
		.br_cond_o    (br_cond),
		.legal_o      (legal)
	);

	operand_bypass u_bypass_rs1 (
		.use_i         (use_rs1),
		.addr_i        (reg1_addr_o),
		.rf_data_i     (reg1_data_i),
		.alt_i         (alt1), // pc for AUIPC
		.ex_wreg_i     (ex_wreg_i),
		.ex_wd_i       (ex_wd_i),
		.ex_wdata_i    (ex_wdata_i),
		.ex_aluop_i    (ex_aluop_i),
		.mem_wreg_i    (mem_wreg_i),
		.mem_wd_i      (mem_wd_i),
		.mem_wdata_i   (mem_wdata_i),
		.mem_aluop_i   (mem_aluop_i),
		.operand_o     (op1),
		.load_hazard_o (hazard1)
	);

	operand_bypass u_bypass_rs2 (
		.use_i         (use_rs2),
		.addr_i        (reg2_addr_o),
		.rf_data_i     (reg2_data_i),
		.alt_i         (dec_imm),
		.ex_wreg_i     (ex_wreg_i),
		.ex_wd_i       (ex_wd_i),
		.ex_wdata_i    (ex_wdata_i),
		.ex_aluop_i    (ex_aluop_i),
		.mem_wreg_i    (mem_wreg_i),
		.mem_wd_i      (mem_wd_i),
		.mem_wdata_i   (mem_wdata_i),
		.mem_aluop_i   (mem_aluop_i),
		.operand_o     (op2),
		.load_hazard_o (hazard2)
	);

	branch_unit u_branch (
		.pc_i        (pc_i),
		.imm_i       (dec_imm),
		.op_a_i      (op1),
		.op_b_i      (op2),
		.is_branch_i (is_branch),
		.is_jal_i    (is_jal),
		.br_cond_i   (br_cond),
		.taken_o     (taken),
		.target_o    (target),
		.link_o      (link)
	);

	assign stall_o = hazard1 | hazard2;

	idex_reg u_idex (
		.clk_i           (clk_i),
		.arst_n_i        (arst_n_i),
		.stall_i         (stall_o),
		.legal_i         (legal),
		.inst_valid_i    (inst_valid_i),
		.aluop_i         (dec_aluop),
		.alusel_i        (dec_alusel),
		.wd_i            (dec_wd),
		.wreg_i          (dec_wreg),
		.reg1_i          (op1),
		.reg2_i          (op2),
		.imm_i           (dec_imm),
		.taken_i         (taken),
		.target_i        (target),
		.link_i          (link),
		.valid_o         (valid_o),
		.illegal_o       (illegal_o),
		.aluop_o         (aluop_o),
		.alusel_o        (alusel_o),
		.wd_o            (wd_o),
		.wreg_o          (wreg_o),
		.reg1_o          (reg1_o),
		.reg2_o          (reg2_o),
		.imm_o           (imm_o),
		.branch_flag_o   (branch_flag_o),
		.branch_target_o (branch_target_o),
		.link_addr_o     (link_addr_o)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
	output logic clk_o,
	output logic arst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #20 clk_o = ~clk_o; // 40 ns period
	end

	initial begin
		arst_n_o = 1'b0;
		repeat (8) @(posedge clk_o);
		#2 arst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

// ==== testbench/id_stage_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module id_stage_assertions (
	input logic clk_i,
	input logic arst_n_i,
	input logic stall_i,
	input logic valid_i,
	input logic illegal_i
);

	property stall_gives_bubble;
		@(posedge clk_i) disable iff (!arst_n_i) stall_i |=> !valid_i;
	endproperty

	property valid_excludes_illegal;
		@(posedge clk_i) !(valid_i && illegal_i);
	endproperty

	property quiet_in_reset;
		@(posedge clk_i) !arst_n_i |-> !valid_i;
	endproperty

	a_stall_bubble: assert property (stall_gives_bubble)
		else $error("valid_o high in the cycle after a stall");
	a_valid_illegal: assert property (valid_excludes_illegal)
		else $error("valid_o and illegal_o high together");
	a_reset_quiet: assert property (quiet_in_reset)
		else $error("valid_o high while reset is held");

endmodule

bind id_stage id_stage_assertions u_assertions (
	.clk_i     (clk_i),
	.arst_n_i  (arst_n_i),
	.stall_i   (stall_o),
	.valid_i   (valid_o),
	.illegal_i (illegal_o)
);

`default_nettype wire

// ==== testbench/tb_id_ref.svh ====
`ifndef TB_ID_REF_SVH
`define TB_ID_REF_SVH

typedef struct packed {
	logic      valid;
	logic      illegal;
	logic      stall;
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	alu_op_e   aluop;
	alu_sel_e  alusel;
	reg_addr_t wd;
	logic      wreg;
	word_t     reg1;
	word_t     reg2;
	word_t     imm;
	logic      br_flag;
	word_t     target;
	word_t     link;
} exp_t;

function automatic logic load_op(input alu_op_e op);
	return (op == ALU_LB) || (op == ALU_LH) || (op == ALU_LW) ||
	       (op == ALU_LBU) || (op == ALU_LHU);
endfunction

function automatic alu_op_e alu_for_f3(input logic [2:0] f3, input logic is_reg,
		input logic b30);
	case (f3)
		3'd0: return (is_reg && b30) ? ALU_SUB : ALU_ADD;
		3'd1: return ALU_SLL;
		3'd2: return ALU_SLT;
		3'd3: return ALU_SLTU;
		3'd4: return ALU_XOR;
		3'd5: return b30 ? ALU_SRA : ALU_SRL;
		3'd6: return ALU_OR;
		default: return ALU_AND;
	endcase
endfunction

function automatic alu_sel_e class_of(input alu_op_e op);
	if (op == ALU_SLL || op == ALU_SRL || op == ALU_SRA)
		return RES_SHIFT;
	if (op == ALU_XOR || op == ALU_OR || op == ALU_AND)
		return RES_LOGIC;
	return RES_ARITH;
endfunction

// EX is younger than MEM, x0 never forwarded
function automatic word_t fwd_operand(input logic use_src, input reg_addr_t addr,
		input word_t rf, input word_t alt, input logic exw, input reg_addr_t exwd,
		input word_t exd, input logic mw, input reg_addr_t mwd, input word_t md);
	if (!use_src)
		return alt;
	if (addr != 5'd0 && exw && exwd == addr)
		return exd;
	if (addr != 5'd0 && mw && mwd == addr)
		return md;
	return rf;
endfunction

function automatic exp_t ref_decode(input logic v, input word_t pc, input word_t inst,
		input word_t rf1, input word_t rf2, input logic exw, input reg_addr_t exwd,
		input word_t exd, input alu_op_e exop, input logic mw, input reg_addr_t mwd,
		input word_t md, input alu_op_e mop);
	exp_t       e;
	logic [6:0] opc;
	logic [2:0] f3;
	reg_addr_t  rs1;
	reg_addr_t  rs2;
	logic       legal;
	alu_op_e    op;
	alu_sel_e   sel;
	logic       wr;
	logic       u1;
	logic       u2;
	logic       br;
	logic       jal;
	logic       cond;
	logic       haz;
	word_t      imm;
	word_t      a;
	word_t      b;
	opc = inst[6:0];
	f3 = inst[14:12];
	rs1 = inst[19:15];
	rs2 = inst[24:20];
	legal = 1'b1;
	op = ALU_NOP;
	sel = RES_NOP;
	{wr, u1, u2, br, jal} = 5'b0;
	imm = '0;
	case (opc)
		7'b0000011: begin
			sel = RES_LOAD_STORE;
			{wr, u1} = 2'b11;
			imm = {{20{inst[31]}}, inst[31:20]};
			case (f3)
				3'd0: op = ALU_LB;
				3'd1: op = ALU_LH;
				3'd2: op = ALU_LW;
				3'd4: op = ALU_LBU;
				3'd5: op = ALU_LHU;
				default: legal = 1'b0;
			endcase
		end
		7'b0100011: begin
			sel = RES_LOAD_STORE;
			{u1, u2} = 2'b11;
			imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			case (f3)
				3'd0: op = ALU_SB;
				3'd1: op = ALU_SH;
				3'd2: op = ALU_SW;
				default: legal = 1'b0;
			endcase
		end
		7'b1100011: begin
			sel = RES_JUMP_BRANCH;
			{u1, u2, br} = 3'b111;
			imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			legal = (f3 != 3'd2) && (f3 != 3'd3);
		end
		7'b1101111: begin
			sel = RES_JUMP_BRANCH;
			{wr, jal} = 2'b11;
			imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		end
		7'b0010011: begin
			op = alu_for_f3(f3, 1'b0, inst[30]);
			sel = class_of(op);
			{wr, u1} = 2'b11;
			if (f3 == 3'd1 || f3 == 3'd5)
				imm = {27'd0, inst[24:20]}; // Shift amount
			else
				imm = {{20{inst[31]}}, inst[31:20]};
		end
		7'b0110011: begin
			op = alu_for_f3(f3, 1'b1, inst[30]);
			sel = class_of(op);
			{wr, u1, u2} = 3'b111;
		end
		7'b0110111: begin
			op = ALU_OR;
			sel = RES_LOGIC;
			wr = 1'b1;
			imm = {inst[31:12], 12'd0};
		end
		7'b0010111: begin
			op = ALU_AUIPC;
			sel = RES_ARITH;
			wr = 1'b1;
			imm = {inst[31:12], 12'd0};
		end
		default: legal = 1'b0;
	endcase
	if (!v || !legal) begin
		op = ALU_NOP;
		sel = RES_NOP;
		{wr, u1, u2, br, jal} = 5'b0;
	end
	a = fwd_operand(u1, rs1, rf1, (op == ALU_AUIPC) ? pc : imm, exw, exwd, exd,
		mw, mwd, md);
	b = fwd_operand(u2, rs2, rf2, imm, exw, exwd, exd, mw, mwd, md);
	haz = (u1 && rs1 != 5'd0 &&
	       ((exwd == rs1 && load_op(exop)) || (mwd == rs1 && load_op(mop)))) ||
	      (u2 && rs2 != 5'd0 &&
	       ((exwd == rs2 && load_op(exop)) || (mwd == rs2 && load_op(mop))));
	case (f3)
		3'd0: cond = (a == b);
		3'd1: cond = (a != b);
		3'd4: cond = ($signed(a) < $signed(b));
		3'd5: cond = ($signed(a) >= $signed(b));
		3'd6: cond = (a < b);
		3'd7: cond = (a >= b);
		default: cond = 1'b0;
	endcase
	e.stall = haz;
	e.rs1_addr = rs1;
	e.rs2_addr = rs2;
	e.valid = v && legal && !haz;
	e.illegal = v && !legal && !haz;
	e.aluop = e.valid ? op : ALU_NOP;
	e.alusel = e.valid ? sel : RES_NOP;
	e.wreg = e.valid && wr;
	e.br_flag = e.valid && (jal || (br && cond));
	e.wd = inst[11:7];
	e.reg1 = a;
	e.reg2 = b;
	e.imm = imm;
	e.target = pc + imm;
	e.link = jal ? pc + 32'd4 : '0;
	return e;
endfunction

`endif

// ==== testbench/tb_id_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_id_stage;
	import id_pkg::*;

	`include "tb_id_ref.svh"

	localparam int TIMEOUT_CYCLES = 2000; // About 420 slots plus reset

	logic      clk;
	logic      arst_n;
	logic      inst_valid;
	word_t     pc;
	word_t     inst;
	word_t     rf1_data;
	word_t     rf2_data;
	logic      ex_wreg;
	reg_addr_t ex_wd;
	word_t     ex_wdata;
	alu_op_e   ex_aluop;
	logic      mem_wreg;
	reg_addr_t mem_wd;
	word_t     mem_wdata;
	alu_op_e   mem_aluop;
	reg_addr_t reg1_addr;
	reg_addr_t reg2_addr;
	logic      stall;
	logic      valid;
	logic      illegal;
	alu_op_e   aluop;
	alu_sel_e  alusel;
	reg_addr_t wd;
	logic      wreg;
	word_t     reg1;
	word_t     reg2;
	word_t     imm;
	logic      branch_flag;
	word_t     branch_target;
	word_t     link_addr;

	exp_t        exp_q[$];
	string       name_q[$];
	exp_t        cur;
	string       nm;
	int          err_count = 0;
	int          cycles = 0;
	logic [15:0] lfsr_state = 16'd82;

	tb_clk_gen u_clk_gen (
		.clk_o    (clk),
		.arst_n_o (arst_n)
	);

	id_stage u_id_stage (
		.clk_i (clk), .arst_n_i (arst_n), .inst_valid_i (inst_valid), .pc_i (pc),
		.inst_i (inst), .reg1_data_i (rf1_data), .reg2_data_i (rf2_data),
		.ex_wreg_i (ex_wreg), .ex_wd_i (ex_wd), .ex_wdata_i (ex_wdata),
		.ex_aluop_i (ex_aluop), .mem_wreg_i (mem_wreg), .mem_wd_i (mem_wd),
		.mem_wdata_i (mem_wdata), .mem_aluop_i (mem_aluop),
		.reg1_addr_o (reg1_addr), .reg2_addr_o (reg2_addr), .stall_o (stall),
		.valid_o (valid), .illegal_o (illegal), .aluop_o (aluop), .alusel_o (alusel),
		.wd_o (wd), .wreg_o (wreg), .reg1_o (reg1), .reg2_o (reg2), .imm_o (imm),
		.branch_flag_o (branch_flag), .branch_target_o (branch_target),
		.link_addr_o (link_addr)
	);

	// Taps 16,14,13,11
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[30:0], lfsr_bit()};
		return r;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			err_count++;
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	task automatic next_slot();
		@(posedge clk);
		#2;
	endtask

	task automatic quiet_pipe();
		ex_wreg = 1'b0;
		ex_wd = 5'(rand_bits(5));
		ex_wdata = rand_bits(32);
		ex_aluop = ALU_NOP;
		mem_wreg = 1'b0;
		mem_wd = 5'(rand_bits(5));
		mem_wdata = rand_bits(32);
		mem_aluop = ALU_NOP;
	endtask

	task automatic random_regs();
		pc = rand_bits(32) & 32'hFFFF_FFFC;
		rf1_data = rand_bits(32);
		rf2_data = rand_bits(32);
	endtask

	task automatic push_expect(input string name, output logic stall_exp);
		exp_t e;
		e = ref_decode(inst_valid, pc, inst, rf1_data, rf2_data, ex_wreg, ex_wd, ex_wdata,
			ex_aluop, mem_wreg, mem_wd, mem_wdata, mem_aluop);
		exp_q.push_back(e);
		name_q.push_back(name);
		stall_exp = e.stall;
	endtask

	task automatic idle_slot(input string name);
		logic s;
		next_slot();
		inst_valid = 1'b0;
		quiet_pipe();
		push_expect(name, s);
	endtask

	task automatic alu_ops_test(input int count);
		logic [1:0] kind;
		logic [2:0] f3;
		reg_addr_t  rd;
		reg_addr_t  rs1;
		reg_addr_t  rs2;
		logic       b30;
		logic       s;
		for (int n = 0; n < count; n++) begin
			next_slot();
			random_regs();
			quiet_pipe();
			kind = 2'(rand_bits(2));
			f3 = 3'(rand_bits(3));
			rd = 5'(rand_bits(5));
			rs1 = 5'(rand_bits(5));
			rs2 = 5'(rand_bits(5));
			b30 = 1'(rand_bits(1));
			case (kind)
				2'd0: inst = {1'b0, (f3 == 3'd0 || f3 == 3'd5) ? b30 : 1'b0, 5'd0, rs2, rs1,
					f3, rd, OPC_OP};
				2'd1: inst = {12'(rand_bits(12)), rs1, f3, rd, OPC_OP_IMM};
				2'd2: inst = {20'(rand_bits(20)), rd, OPC_LUI};
				default: inst = {20'(rand_bits(20)), rd, OPC_AUIPC};
			endcase
			inst_valid = 1'b1;
			push_expect("alu", s);
		end
	endtask

	task automatic forwarding_test(input int count);
		logic [1:0] kind;
		reg_addr_t  rd;
		reg_addr_t  rs1;
		reg_addr_t  rs2;
		logic       s;
		for (int n = 0; n < count; n++) begin
			next_slot();
			random_regs();
			quiet_pipe();
			kind = 2'(rand_bits(2));
			rd = 5'(rand_bits(5));
			rs1 = 5'(rand_bits(5));
			rs2 = 5'(rand_bits(5));
			ex_wreg = 1'b1;
			mem_wreg = 1'b1;
			ex_aluop = ALU_ADD;
			mem_aluop = ALU_SUB;
			case (kind)
				2'd0: {ex_wd, mem_wd} = {rs1, rs1}; // Both match, EX wins
				2'd1: {ex_wd, mem_wd} = {rs1 ^ 5'd1, rs1};
				2'd2: begin
					rs1 = 5'd0;
					{ex_wd, mem_wd} = 10'd0;
				end
				default: {ex_wd, mem_wd} = {rs2, rs1};
			endcase
			inst = {7'd0, rs2, rs1, 3'(rand_bits(3)), rd, OPC_OP};
			inst_valid = 1'b1;
			push_expect("forward", s);
		end
	endtask

	task automatic load_store_test(input int count);
		logic       is_ld;
		logic [1:0] hz;
		logic [2:0] f3;
		logic [11:0] ofs;
		reg_addr_t  rs1;
		reg_addr_t  rs2;
		logic       s;
		for (int n = 0; n < count; n++) begin
			next_slot();
			random_regs();
			quiet_pipe();
			is_ld = 1'(rand_bits(1));
			hz = 2'(rand_bits(2));
			ofs = 12'(rand_bits(12));
			rs1 = 5'(rand_bits(5));
			rs2 = 5'(rand_bits(5));
			if (is_ld) begin
				f3 = 3'(rand_bits(3));
				if (f3 == 3'd3 || f3[2:1] == 2'b11)
					f3 = 3'd2; // Unused widths become LW
				inst = {ofs, rs1, f3, 5'(rand_bits(5)), OPC_LOAD};
			end else begin
				f3 = {1'b0, 2'(rand_bits(2))};
				if (f3 == 3'd3)
					f3 = 3'd2;
				inst = {ofs[11:5], rs2, rs1, f3, ofs[4:0], OPC_STORE};
			end
			if (hz == 2'd0) begin
				ex_wreg = 1'b1;
				ex_wd = rs1;
				ex_aluop = ALU_LW;
			end else if (hz == 2'd1) begin
				mem_wreg = 1'b1;
				mem_wd = rs2;
				mem_aluop = ALU_LBU;
			end
			inst_valid = 1'b1;
			push_expect(is_ld ? "load" : "store", s);
			if (s) begin
				// Hold the instruction until the load has left
				next_slot();
				quiet_pipe();
				push_expect("after stall", s);
			end
		end
	endtask

	task automatic branch_test(input int count);
		logic [1:0]  kind;
		logic [1:0]  fwd;
		logic [2:0]  f3;
		logic [12:0] ofs;
		logic [20:0] jofs;
		reg_addr_t   rs1;
		reg_addr_t   rs2;
		logic        s;
		for (int n = 0; n < count; n++) begin
			next_slot();
			random_regs();
			quiet_pipe();
			kind = 2'(rand_bits(2));
			fwd = 2'(rand_bits(2));
			f3 = 3'(rand_bits(3));
			if (f3[2:1] == 2'b01)
				f3 = f3 | 3'b100;
			ofs = 13'(rand_bits(13));
			jofs = 21'(rand_bits(21));
			rs1 = 5'(rand_bits(5));
			rs2 = 5'(rand_bits(5));
			if (1'(rand_bits(1)))
				rf2_data = rf1_data;
			if (fwd == 2'd1) begin
				ex_wreg = 1'b1;
				ex_wd = rs1;
				ex_aluop = ALU_ADD;
			end else if (fwd == 2'd2) begin
				mem_wreg = 1'b1;
				mem_wd = rs2;
				mem_aluop = ALU_XOR;
				mem_wdata = rf1_data;
			end
			if (kind == 2'd3)
				inst = {jofs[20], jofs[10:1], jofs[11], jofs[19:12], 5'(rand_bits(5)),
					OPC_JAL};
			else
				inst = {ofs[12], ofs[10:5], rs2, rs1, f3, ofs[4:1], ofs[11], OPC_BRANCH};
			inst_valid = 1'b1;
			push_expect(kind == 2'd3 ? "jal" : "branch", s);
		end
	endtask

	task automatic illegal_test(input int count);
		logic [1:0] kind;
		logic       s;
		for (int n = 0; n < count; n++) begin
			next_slot();
			random_regs();
			quiet_pipe();
			kind = 2'(rand_bits(2));
			case (kind)
				2'd0: inst = {25'(rand_bits(25)), 7'b1100111};
				2'd1: inst = {17'(rand_bits(17)), 3'b011, 5'(rand_bits(5)), OPC_LOAD};
				2'd2: inst = {25'(rand_bits(25)), 7'b1111111};
				default: inst = {17'(rand_bits(17)), 3'b010, 5'(rand_bits(5)), OPC_BRANCH};
			endcase
			inst_valid = 1'b1;
			push_expect("illegal", s);
		end
	endtask

	// Registered results one cycle late, stall and addresses in the same cycle
	always @(negedge clk) begin
		if (exp_q.size() >= 2) begin
			cur = exp_q.pop_front();
			nm = name_q.pop_front();
			check({nm, " valid"}, 32'(cur.valid), 32'(valid));
			check({nm, " illegal"}, 32'(cur.illegal), 32'(illegal));
			check({nm, " aluop"}, 32'(cur.aluop), 32'(aluop));
			check({nm, " alusel"}, 32'(cur.alusel), 32'(alusel));
			check({nm, " wreg"}, 32'(cur.wreg), 32'(wreg));
			check({nm, " branch_flag"}, 32'(cur.br_flag), 32'(branch_flag));
			if (cur.valid) begin
				check({nm, " wd"}, 32'(cur.wd), 32'(wd));
				check({nm, " reg1"}, cur.reg1, reg1);
				check({nm, " reg2"}, cur.reg2, reg2);
				check({nm, " imm"}, cur.imm, imm);
				check({nm, " target"}, cur.target, branch_target);
				check({nm, " link"}, cur.link, link_addr);
			end
		end
		if (exp_q.size() >= 1) begin
			check({name_q[0], " stall"}, 32'(exp_q[0].stall), 32'(stall));
			check({name_q[0], " reg1_addr"}, 32'(exp_q[0].rs1_addr), 32'(reg1_addr));
			check({name_q[0], " reg2_addr"}, 32'(exp_q[0].rs2_addr), 32'(reg2_addr));
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Error: simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Result: FAILED");
			$fatal(1, "Timeout");
		end
	end

	initial begin
		inst_valid = 1'b0;
		{pc, inst, rf1_data, rf2_data} = '0;
		{ex_wreg, ex_wd, ex_wdata} = '0;
		{mem_wreg, mem_wd, mem_wdata} = '0;
		ex_aluop = ALU_NOP;
		mem_aluop = ALU_NOP;
		repeat (4) begin
			@(negedge clk);
			check("reset valid", 32'd0, 32'(valid));
			check("reset wreg", 32'd0, 32'(wreg));
			check("reset branch_flag", 32'd0, 32'(branch_flag));
			check("reset illegal", 32'd0, 32'(illegal));
			check("reset aluop", 32'(ALU_NOP), 32'(aluop));
		end
		wait (arst_n);
		idle_slot("post reset");
		alu_ops_test(120);
		forwarding_test(80);
		load_store_test(80);
		branch_test(90);
		illegal_test(30);
		repeat (3) idle_slot("drain");
		repeat (2) @(negedge clk);
		if (err_count == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			$display("Result: FAILED");
			$fatal(1, "%0d checks failed", err_count);
		end
	end

endmodule

`default_nettype wire

// ==== id_stage.f ====
+incdir+testbench
verilog/id_pkg.sv
verilog/inst_decoder.sv
verilog/operand_bypass.sv
verilog/branch_unit.sv
verilog/idex_reg.sv
verilog/id_stage.sv
testbench/tb_clk_gen.sv
testbench/id_stage_assertions.sv
testbench/tb_id_stage.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the ID stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_id_stage -f id_stage.f \
	-o tb_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1

grep -q "^Result: PASSED$" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
